// File: hdl/acc_cpu_pkg.sv
package acc_cpu_pkg;

    typedef logic [15:0] word_t; // One data word
    typedef logic [11:0] addr_t; // One word address

    // Instruction opcode, upper nibble of the word
    typedef enum logic [3:0] {
        op_add   = 4'h0, // AC + M
        op_halt  = 4'h1, // Stop the machine
        op_load  = 4'h2, // AC = M
        op_store = 4'h3, // M = AC
        op_clear = 4'h4, // AC = 0
        op_skip  = 4'h5, // Conditional skip
        op_jump  = 4'h6, // PC = address field
        op_sub   = 4'h7, // AC - M
        op_and   = 4'h8,
        op_or    = 4'h9,
        op_xor   = 4'ha,
        op_shl   = 4'hb, // Shift left by one
        op_shr   = 4'hc, // Logical shift right by one
        op_rol   = 4'hd,
        op_ror   = 4'he,
        op_nop   = 4'hf
    } opcode_e;

    // ALU function select
    typedef enum logic [3:0] {
        alu_pass  = 4'h0, // Result is operand b
        alu_add   = 4'h1,
        alu_sub   = 4'h2,
        alu_and   = 4'h3,
        alu_or    = 4'h4,
        alu_xor   = 4'h5,
        alu_shl   = 4'h6,
        alu_shr   = 4'h7,
        alu_rol   = 4'h8,
        alu_ror   = 4'h9,
        alu_clear = 4'ha
    } alu_op_e;

    // SKIP condition codes carried in the address field
    localparam addr_t skip_if_neg  = 12'd0;
    localparam addr_t skip_if_zero = 12'd2;
    localparam addr_t skip_if_pos  = 12'd4;

    // One request towards the shared memory
    typedef struct packed {
        logic  req;   // Level, held until granted
        logic  we;    // Write when set, read otherwise
        addr_t addr;  // Word address
        word_t wdata; // Write data
    } mem_req_t;

    // Client that a pending read return belongs to
    typedef enum logic [1:0] {
        own_none  = 2'd0,
        own_host  = 2'd1,
        own_exec  = 2'd2,
        own_fetch = 2'd3
    } owner_e;

endpackage

// File: hdl/alu.sv
module alu (
    input  acc_cpu_pkg::alu_op_e op,       // Function select
    input  acc_cpu_pkg::word_t   a,        // Accumulator side
    input  acc_cpu_pkg::word_t   b,        // Memory operand side
    output acc_cpu_pkg::word_t   result,
    input  acc_cpu_pkg::addr_t   cond_sel, // SKIP condition code
    output logic                 cond_true
);
    import acc_cpu_pkg::*;

    logic a_neg;  // Sign of a
    logic a_zero;

    assign a_neg  = a[15];
    assign a_zero = (a == '0);

    always_comb begin
        case (op)
            alu_pass:  result = b;                  // LOAD path
            alu_add:   result = a + b;              // Wraps at 16 bits
            alu_sub:   result = a - b;              // Wraps at 16 bits
            alu_and:   result = a & b;
            alu_or:    result = a | b;
            alu_xor:   result = a ^ b;
            alu_shl:   result = {a[14:0], 1'b0};
            alu_shr:   result = {1'b0, a[15:1]};    // Logical, zero fill
            alu_rol:   result = {a[14:0], a[15]};
            alu_ror:   result = {a[0], a[15:1]};
            alu_clear: result = '0;
            default:   result = a;                  // Unused codes keep AC
        endcase
    end

    // SKIP test treats a as signed
    always_comb begin
        case (cond_sel)
            skip_if_neg:  cond_true = a_neg;
            skip_if_zero: cond_true = a_zero;
            skip_if_pos:  cond_true = !a_neg && !a_zero; // Strictly positive
            default:      cond_true = 1'b0;              // Never skips
        endcase
    end

endmodule

// File: hdl/unified_mem.sv
module unified_mem #(
    parameter int MEM_WORDS = 4096 // Depth in words
) (
    input  logic                  clk,
    input  acc_cpu_pkg::mem_req_t mem_req, // Granted request from arbiter
    output acc_cpu_pkg::word_t    rdata    // Valid one cycle after a read
);
    import acc_cpu_pkg::*;

    word_t mem_array [MEM_WORDS]; // Program and data share this array

    // Write side
    always_ff @(posedge clk) begin
        if (mem_req.req && mem_req.we) begin
            mem_array[mem_req.addr] <= mem_req.wdata;
        end
    end

    // Read side, data held until next read
    always_ff @(posedge clk) begin
        if (mem_req.req && !mem_req.we) begin
            rdata <= mem_array[mem_req.addr];
        end
    end

endmodule

// File: hdl/mem_arbiter.sv
module mem_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  acc_cpu_pkg::mem_req_t host_req,     // Highest priority
    input  acc_cpu_pkg::mem_req_t exec_req,
    input  acc_cpu_pkg::mem_req_t fetch_req,    // Lowest priority
    output logic                  host_grant,
    output logic                  exec_grant,
    output logic                  fetch_grant,
    output acc_cpu_pkg::mem_req_t mem_req,      // Winning request
    output logic                  host_rvalid,
    output logic                  exec_rvalid,
    output logic                  fetch_rvalid
);
    import acc_cpu_pkg::*;

    owner_e winner;  // Client granted this cycle
    owner_e owner_q; // Owner of the read now returning

    // Fixed priority, one grant per cycle
    assign host_grant  = host_req.req;
    assign exec_grant  = exec_req.req && !host_req.req;
    assign fetch_grant = fetch_req.req && !host_req.req && !exec_req.req;

    always_comb begin
        mem_req = '0; // Idle memory when nobody asks
        winner  = own_none;
        if (host_grant) begin
            mem_req = host_req;
            winner  = own_host;
        end else if (exec_grant) begin
            mem_req = exec_req;
            winner  = own_exec;
        end else if (fetch_grant) begin
            mem_req = fetch_req;
            winner  = own_fetch;
        end
    end

    // Remember who gets the read data next cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owner_q <= own_none;
        end else if (mem_req.req && !mem_req.we) begin
            owner_q <= winner;
        end else begin
            owner_q <= own_none; // Writes return nothing
        end
    end

    // One-cycle return pulses
    assign host_rvalid  = (owner_q == own_host);
    assign exec_rvalid  = (owner_q == own_exec);
    assign fetch_rvalid = (owner_q == own_fetch);

endmodule

// File: hdl/fetch_unit.sv
module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,       // Run and not halted
    output acc_cpu_pkg::mem_req_t fetch_req,
    input  logic                  fetch_grant,
    input  logic                  fetch_rvalid,
    input  acc_cpu_pkg::word_t    rdata,
    output acc_cpu_pkg::word_t    instr,        // Buffered instruction
    output acc_cpu_pkg::addr_t    instr_pc,     // Its address
    output logic                  instr_valid,
    input  logic                  instr_take,   // Execute starts it
    input  logic                  retire,
    input  logic                  redirect,     // Qualified by retire
    input  acc_cpu_pkg::addr_t    redirect_pc
);
    import acc_cpu_pkg::*;

    addr_t pc;             // Next address to fetch
    logic  epoch;          // Flips on every redirect
    logic  inflight;       // Read granted last cycle
    logic  inflight_epoch; // Epoch of that read
    addr_t inflight_pc;
    logic  buf_valid;
    word_t buf_instr;
    addr_t buf_pc;
    logic  take_redirect;
    logic  fill;           // Return belongs to current epoch

    assign take_redirect = retire && redirect;
    assign fill          = fetch_rvalid && (inflight_epoch == epoch);

    // Ask when the buffer is free or emptying and nothing is in flight
    assign fetch_req.req   = enable && !inflight && (!buf_valid || instr_take);
    assign fetch_req.we    = 1'b0;      // Fetch only reads
    assign fetch_req.addr  = pc;
    assign fetch_req.wdata = '0;

    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;
    assign instr_valid = buf_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc             <= '0;
            epoch          <= 1'b0;
            inflight       <= 1'b0;
            inflight_epoch <= 1'b0;
            buf_valid      <= 1'b0;
        end else begin
            if (fetch_grant) begin
                inflight       <= 1'b1;
                inflight_epoch <= epoch; // Stale if redirected meanwhile
            end else if (fetch_rvalid) begin
                inflight <= 1'b0;
            end

            if (take_redirect) begin
                pc        <= redirect_pc; // Restart at new target
                epoch     <= ~epoch;      // Drops any read in flight
                buf_valid <= 1'b0;        // Discard prefetched word
            end else begin
                if (fetch_grant) begin
                    pc <= pc + 12'd1;     // Wraps 4095 to 0
                end
                if (fill) begin
                    buf_valid <= 1'b1;
                end else if (instr_take) begin
                    buf_valid <= 1'b0;
                end
            end
        end
    end

    // Buffer payload
    always_ff @(posedge clk) begin
        if (fetch_grant) begin
            inflight_pc <= pc;
        end
        if (fill) begin
            buf_instr <= rdata;
            buf_pc    <= inflight_pc;
        end
    end

endmodule

// File: hdl/execute_unit.sv
module execute_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,      // Run and not halted
    input  acc_cpu_pkg::word_t    instr,
    input  acc_cpu_pkg::addr_t    instr_pc,
    input  logic                  instr_valid,
    output logic                  instr_take,  // Start pulse
    output acc_cpu_pkg::mem_req_t exec_req,
    input  logic                  exec_grant,
    input  logic                  exec_rvalid,
    input  acc_cpu_pkg::word_t    rdata,
    output logic                  retire,      // Done pulse
    output logic                  redirect,
    output acc_cpu_pkg::addr_t    redirect_pc,
    output acc_cpu_pkg::word_t    acc_out,
    output logic                  halted
);
    import acc_cpu_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_mem_access, // Request held until granted
        s_mem_wait,   // Read data due
        s_write_back  // Update AC and retire
    } state_e;

    state_e  state;
    word_t   ir;        // Instruction register
    addr_t   ir_pc;     // Address of current instruction
    addr_t   mar;       // Operand address / jump target / skip code
    word_t   mbr;       // Operand read from memory
    word_t   ac;        // Accumulator
    opcode_e ir_op;
    opcode_e new_op;    // Opcode of the word offered by fetch
    alu_op_e alu_op;
    logic    ac_write;  // Opcode updates AC
    word_t   alu_result;
    logic    cond_true;

    assign ir_op  = opcode_e'(ir[15:12]);
    assign new_op = opcode_e'(instr[15:12]);

    // Decode for the ALU
    always_comb begin
        ac_write = 1'b1;
        case (ir_op)
            op_load:  alu_op = alu_pass;
            op_add:   alu_op = alu_add;
            op_sub:   alu_op = alu_sub;
            op_and:   alu_op = alu_and;
            op_or:    alu_op = alu_or;
            op_xor:   alu_op = alu_xor;
            op_shl:   alu_op = alu_shl;
            op_shr:   alu_op = alu_shr;
            op_rol:   alu_op = alu_rol;
            op_ror:   alu_op = alu_ror;
            op_clear: alu_op = alu_clear;
            default: begin
                alu_op   = alu_pass; // HALT, STORE, SKIP, JUMP, NOP
                ac_write = 1'b0;
            end
        endcase
    end

    alu u_alu (
        .op        (alu_op),
        .a         (ac),
        .b         (mbr),
        .result    (alu_result),
        .cond_sel  (mar),
        .cond_true (cond_true)
    );

    assign instr_take = (state == s_idle) && enable && instr_valid;

    assign exec_req.req   = (state == s_mem_access);
    assign exec_req.we    = (ir_op == op_store);
    assign exec_req.addr  = mar;
    assign exec_req.wdata = ac;

    assign retire      = (state == s_write_back);
    assign redirect    = retire && ((ir_op == op_jump) || ((ir_op == op_skip) && cond_true));
    assign redirect_pc = (ir_op == op_jump) ? mar : ir_pc + 12'd2; // Skip lands past next
    assign acc_out     = ac;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= s_idle;
            ac     <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (instr_take) begin
                        case (new_op)
                            op_add, op_load, op_store, op_sub,
                            op_and, op_or, op_xor: state <= s_mem_access;
                            default:               state <= s_write_back;
                        endcase
                    end
                end
                s_mem_access: begin
                    if (exec_grant) begin
                        state <= exec_req.we ? s_write_back : s_mem_wait; // Store done at grant
                    end
                end
                s_mem_wait: begin
                    if (exec_rvalid) begin
                        state <= s_write_back;
                    end
                end
                s_write_back: begin
                    if (ac_write) begin
                        ac <= alu_result;
                    end
                    if (ir_op == op_halt) begin
                        halted <= 1'b1; // Sticky until reset
                    end
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // IR, MAR and MBR payload
    always_ff @(posedge clk) begin
        if (instr_take) begin
            ir    <= instr;
            ir_pc <= instr_pc;
            mar   <= instr[11:0];
        end
        if (exec_rvalid) begin
            mbr <= rdata;
        end
    end

endmodule

// File: hdl/acc_cpu_top.sv
module acc_cpu_top #(
    parameter int MEM_WORDS = 4096 // Memory depth
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,         // Processor runs while high
    input  logic               host_wr,
    input  logic               host_rd,
    input  acc_cpu_pkg::addr_t host_addr,
    input  acc_cpu_pkg::word_t host_wdata,
    output acc_cpu_pkg::word_t host_rdata,
    output logic               host_rvalid, // One cycle after host_rd
    output acc_cpu_pkg::word_t acc_out,
    output logic               halted
);
    import acc_cpu_pkg::*;

    mem_req_t host_req;
    mem_req_t exec_req;
    mem_req_t fetch_req;
    mem_req_t mem_req;     // Arbiter winner
    logic     exec_grant;
    logic     fetch_grant;
    logic     exec_rvalid;
    logic     fetch_rvalid;
    word_t    mem_rdata;   // Shared read return
    logic     cpu_enable;
    word_t    instr;
    addr_t    instr_pc;
    logic     instr_valid;
    logic     instr_take;
    logic     retire;
    logic     redirect;
    addr_t    redirect_pc;

    // Host port as a memory client
    assign host_req.req   = host_wr || host_rd;
    assign host_req.we    = host_wr;
    assign host_req.addr  = host_addr;
    assign host_req.wdata = host_wdata;

    assign cpu_enable = run && !halted;
    assign host_rdata = mem_rdata;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .reset        (reset),
        .enable       (cpu_enable),
        .fetch_req    (fetch_req),
        .fetch_grant  (fetch_grant),
        .fetch_rvalid (fetch_rvalid),
        .rdata        (mem_rdata),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_valid  (instr_valid),
        .instr_take   (instr_take),
        .retire       (retire),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    execute_unit u_execute_unit (
        .clk         (clk),
        .reset       (reset),
        .enable      (cpu_enable),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .instr_take  (instr_take),
        .exec_req    (exec_req),
        .exec_grant  (exec_grant),
        .exec_rvalid (exec_rvalid),
        .rdata       (mem_rdata),
        .retire      (retire),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .acc_out     (acc_out),
        .halted      (halted)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .reset        (reset),
        .host_req     (host_req),
        .exec_req     (exec_req),
        .fetch_req    (fetch_req),
        .host_grant   (),            // Host always wins
        .exec_grant   (exec_grant),
        .fetch_grant  (fetch_grant),
        .mem_req      (mem_req),
        .host_rvalid  (host_rvalid),
        .exec_rvalid  (exec_rvalid),
        .fetch_rvalid (fetch_rvalid)
    );

    unified_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_unified_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

endmodule

// File: tests/acc_cpu_tb_tasks.svh
task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
endtask

task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic reset_cpu();
    run   = 1'b0;
    reset = 1'b1;
    repeat (reset_cycles) next_cycle();
    reset = 1'b0;
endtask

task automatic host_write(addr_t addr, word_t data);
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    next_cycle(); // Written at this edge
    host_wr = 1'b0;
endtask

task automatic host_read(input addr_t addr, output word_t data);
    host_rd   = 1'b1;
    host_addr = addr;
    next_cycle();
    host_rd = 1'b0;
    check_bit("host_rvalid", host_rvalid, 1'b1); // Due one cycle after host_rd
    data = host_rdata;
endtask

function automatic word_t instr_word(opcode_e op, addr_t field);
    return {op, field};
endfunction

task automatic clear_program();
    load_list.delete();
    check_list.delete();
endtask

task automatic put_word(addr_t addr, word_t data);
    model_mem[addr] = data;
    load_list.push_back(addr);
endtask

// Preloaded word that is read back after the run
task automatic watch_word(addr_t addr, word_t init);
    put_word(addr, init);
    check_list.push_back(addr);
endtask

task automatic run_program(int prog_words, int hold_cycles);
    word_t exp_acc;
    word_t got;
    int    waited;
    reset_cpu();
    check_bit("halted", halted, 1'b0); // Clear after reset
    check_bit("host_rvalid", host_rvalid, 1'b0);
    check_word("acc_out", acc_out, 16'h0000);
    foreach (load_list[i]) host_write(load_list[i], model_mem[load_list[i]]);
    run    = 1'b1;
    waited = 0;
    while (!halted && waited < prog_words * cycles_per_word + 200) begin
        next_cycle();
        waited++;
    end
    if (!halted) begin
        errors++;
        $display("Processor did not halt within %0d cycles at %0t", waited, $time);
    end
    exp_acc = model_execute(1000);
    check_word("acc_out", acc_out, exp_acc);
    repeat (hold_cycles) begin // Run stays high after halt
        next_cycle();
        check_bit("halted", halted, 1'b1);
        check_word("acc_out after halt", acc_out, exp_acc);
    end
    run = 1'b0;
    foreach (check_list[i]) begin
        host_read(check_list[i], got);
        check_word($sformatf("mem[%h]", check_list[i]), got, model_mem[check_list[i]]);
    end
endtask

task automatic test_host_access();
    addr_t addrs [8];
    word_t datas [8];
    word_t got;
    reset_cpu();
    for (int i = 0; i < 8; i++) begin
        addrs[i]        = addr_t'($random(seed));
        addrs[i][11:9]  = 3'(i); // Keeps addresses distinct
        datas[i]        = word_t'($random(seed));
        host_write(addrs[i], datas[i]);
    end
    for (int i = 0; i < 8; i++) begin
        host_read(addrs[i], got);
        check_word("host_rdata", got, datas[i]);
    end
endtask

task automatic test_arith();
    clear_program();
    put_word(12'd0, instr_word(op_load, 12'd100));
    put_word(12'd1, instr_word(op_add, 12'd101));
    put_word(12'd2, instr_word(op_store, 12'd200));
    put_word(12'd3, instr_word(op_sub, 12'd102));
    put_word(12'd4, instr_word(op_store, 12'd201));
    put_word(12'd5, instr_word(op_halt, 12'd0));
    put_word(12'd100, word_t'($random(seed)) | 16'h8000); // Both high so the sum wraps
    put_word(12'd101, word_t'($random(seed)) | 16'h8000);
    put_word(12'd102, word_t'($random(seed)));
    watch_word(12'd200, 16'h0000);
    watch_word(12'd201, 16'h0000);
    run_program(6, 0);
endtask

task automatic test_logic_shift();
    clear_program();
    put_word(12'd0, instr_word(op_load, 12'd100));
    put_word(12'd1, instr_word(op_and, 12'd101));
    put_word(12'd2, instr_word(op_or, 12'd102));
    put_word(12'd3, instr_word(op_xor, 12'd103));
    put_word(12'd4, instr_word(op_store, 12'd200));
    put_word(12'd5, instr_word(op_shl, 12'd0));
    put_word(12'd6, instr_word(op_rol, 12'd0)); // Carries the shifted-in zero around
    put_word(12'd7, instr_word(op_shr, 12'd0));
    put_word(12'd8, instr_word(op_ror, 12'd0));
    put_word(12'd9, instr_word(op_ror, 12'd0));
    put_word(12'd10, instr_word(op_store, 12'd201));
    put_word(12'd11, instr_word(op_clear, 12'd0));
    put_word(12'd12, instr_word(op_or, 12'd103));
    put_word(12'd13, instr_word(op_halt, 12'd0));
    for (int i = 0; i < 4; i++) put_word(12'd100 + 12'(i), word_t'($random(seed)));
    watch_word(12'd200, 16'h0000);
    watch_word(12'd201, 16'h0000);
    run_program(14, 0);
endtask

task automatic test_skip();
    addr_t conds [3];
    word_t value;
    conds = '{12'd0, 12'd2, 12'd4}; // Negative, zero, positive tests
    for (int c = 0; c < 3; c++) begin
        for (int v = 0; v < 3; v++) begin
            case (v)
                0:       value = word_t'($random(seed)) | 16'h8000;
                1:       value = 16'h0000;
                default: value = (word_t'($random(seed)) & 16'h7fff) | 16'h0001;
            endcase
            clear_program();
            put_word(12'd0, instr_word(op_load, 12'd100));
            put_word(12'd1, instr_word(op_skip, conds[c]));
            put_word(12'd2, instr_word(op_store, 12'd300)); // Skipped or not
            put_word(12'd3, instr_word(op_halt, 12'd0));
            put_word(12'd100, value);
            watch_word(12'd300, 16'h5a5a); // Marker
            run_program(4, 0);
        end
    end
endtask

task automatic test_jump_halt();
    clear_program();
    put_word(12'd0, instr_word(op_load, 12'd100));
    put_word(12'd1, instr_word(op_jump, 12'd3));
    put_word(12'd2, instr_word(op_store, 12'd300)); // Jumped over
    put_word(12'd3, instr_word(op_store, 12'd301));
    put_word(12'd4, instr_word(op_halt, 12'd0));
    put_word(12'd100, word_t'($random(seed)));
    watch_word(12'd300, 16'hc3c3);
    watch_word(12'd301, 16'h0000);
    run_program(5, 0);

    // Countdown loop back to SUB until AC reaches zero
    clear_program();
    put_word(12'd0, instr_word(op_load, 12'd100));
    put_word(12'd1, instr_word(op_sub, 12'd101));
    put_word(12'd2, instr_word(op_skip, 12'd2));
    put_word(12'd3, instr_word(op_jump, 12'd1));
    put_word(12'd4, instr_word(op_add, 12'd102));
    put_word(12'd5, instr_word(op_halt, 12'd0));
    put_word(12'd100, 16'd3 + (word_t'($random(seed)) & 16'h0003));
    put_word(12'd101, 16'd1);
    put_word(12'd102, word_t'($random(seed)));
    run_program(6, 20);
endtask

// File: tests/acc_cpu_tb.sv
module acc_cpu_tb;
    import acc_cpu_pkg::*;

    localparam int clk_period      = 40;
    localparam int drive_delay     = 5;   // Input drive after rising edge
    localparam int reset_cycles    = 16;
    localparam int cycles_per_word = 20;  // Halt budget per program word
    // Program words over all runs: 6 + 14 + 9 * 4 + 5 + 6
    localparam int total_prog_words = 67;
    localparam int margin_cycles    = 4000; // Resets, host loads, readbacks
    localparam int watchdog_cycles  = total_prog_words * cycles_per_word + margin_cycles;

    logic  clk;
    logic  reset;
    logic  run;
    logic  host_wr;
    logic  host_rd;
    addr_t host_addr;
    word_t host_wdata;
    word_t host_rdata;
    logic  host_rvalid;
    word_t acc_out;
    logic  halted;

    integer seed = 32'h085732c2; // Fixed seed for repeatable operands
    int     errors = 0;
    int     checks = 0;

    word_t model_mem [4096]; // Reference copy of program and data
    addr_t load_list [$];    // Words to load before a run
    addr_t check_list [$];   // Words to read back after a run

    acc_cpu_top #(
        .MEM_WORDS (4096)
    ) u_acc_cpu_top (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .host_wr     (host_wr),
        .host_rd     (host_rd),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .acc_out     (acc_out),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired before the test sequence finished");
        $display("Some tests failed");
        $finish;
    end

    // Reference interpreter, runs from address 0 until HALT
    function automatic word_t model_execute(int max_steps);
        addr_t pc;
        addr_t field;
        word_t ir;
        word_t ac;
        word_t opnd;
        int    steps;
        logic  done;
        pc    = '0;
        ac    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < max_steps) begin
            ir    = model_mem[pc];
            field = ir[11:0];
            opnd  = model_mem[field];
            pc    = pc + 12'd1; // Wraps at 4096
            steps++;
            case (opcode_e'(ir[15:12]))
                op_add:   ac = ac + opnd;
                op_halt:  done = 1'b1;
                op_load:  ac = opnd;
                op_store: model_mem[field] = ac;
                op_clear: ac = '0;
                op_skip: begin
                    if ((field == 12'd0 && ac[15]) || (field == 12'd2 && ac == 16'd0) ||
                        (field == 12'd4 && !ac[15] && ac != 16'd0)) begin
                        pc = pc + 12'd1; // Step over next word
                    end
                end
                op_jump:  pc = field;
                op_sub:   ac = ac - opnd;
                op_and:   ac = ac & opnd;
                op_or:    ac = ac | opnd;
                op_xor:   ac = ac ^ opnd;
                op_shl:   ac = ac << 1;
                op_shr:   ac = ac >> 1;
                op_rol:   ac = (ac << 1) | (ac >> 15);
                op_ror:   ac = (ac >> 1) | (ac << 15);
                default:  ; // NOP
            endcase
        end
        return ac;
    endfunction

    `include "acc_cpu_tb_tasks.svh"

    initial begin
        run        = 1'b0;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        reset      = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        test_host_access();
        test_arith();
        test_logic_shift();
        test_skip();
        test_jump_halt();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
hdl/acc_cpu_pkg.sv
hdl/alu.sv
hdl/unified_mem.sv
hdl/mem_arbiter.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/acc_cpu_top.sv
tests/acc_cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the accumulator CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module acc_cpu_tb \
    -Mdir obj_dir \
    -f verilog.f

output=$(./obj_dir/Vacc_cpu_tb)
echo "$output"

if grep -q "^All tests passed$" <<< "$output"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
